// ==== src/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// First instruction fetched after reset
`define MIPS_RESET_VECTOR 32'hBFC0_0000

// A fetch from this address stops the core
`define MIPS_HALT_ADDR 32'h0000_0000

`define MIPS_NUM_REGS 32

`endif

// ==== src/mips_pkg.sv ====
package mips_pkg;

  typedef logic [31:0] size_t;
  typedef logic [4:0] regaddr_t;

  // Primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_ORI     = 6'h0D,
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_t;

  // Function field of SPECIAL, instr[5:0]
  typedef enum logic [5:0] {
    FUNC_JR   = 6'h08,
    FUNC_ADDU = 6'h21,
    FUNC_SUBU = 6'h23,
    FUNC_AND  = 6'h24,
    FUNC_OR   = 6'h25,
    FUNC_XOR  = 6'h26,
    FUNC_SLT  = 6'h2A
  } func_t;

  typedef enum logic [2:0] {
    FETCH,
    EXEC,
    MEM,
    WRITEBACK,
    HALT
  } state_t;

  // R-type writes rd, I-type writes rt
  typedef enum logic {
    REGFILE_ADDR_SEL_RD,
    REGFILE_ADDR_SEL_RT
  } regfile_addr_sel_t;

endpackage

// ==== src/mips_fsm.sv ====
module mips_fsm (
  input  logic             clk,
  input  logic             arst_n_i,
  input  logic             stall_i,
  input  logic             halt_i,
  input  logic             is_mem_i,
  input  logic             is_branch_i,
  output mips_pkg::state_t state_o
);
  import mips_pkg::*;

  state_t state_q;
  state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH: begin
        if (halt_i) begin
          state_d = HALT;
        end else if (!stall_i) begin
          state_d = EXEC;
        end
      end
      EXEC: begin
        if (is_mem_i) begin
          state_d = MEM;
        end else if (is_branch_i) begin
          // Branches and JR have nothing to write back
          state_d = FETCH;
        end else begin
          state_d = WRITEBACK;
        end
      end
      MEM: begin
        if (!stall_i) begin
          state_d = WRITEBACK;
        end
      end
      WRITEBACK: state_d = FETCH;
      // Parked until the next reset
      HALT: state_d = HALT;
      default: state_d = HALT;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= FETCH;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

// ==== src/mips_control.sv ====
module mips_control (
  input  mips_pkg::state_t            state_i,
  input  mips_pkg::opcode_t           opcode_i,
  input  mips_pkg::func_t             function_i,
  output logic                        pc_write_en_o,
  output logic                        ir_write_en_o,
  output logic                        ram_read_en_o,
  output logic                        ram_write_en_o,
  output logic                        ram_addr_sel_o,
  output logic                        src_b_sel_o,
  output logic                        regfile_write_en_o,
  output mips_pkg::regfile_addr_sel_t regfile_addr_3_sel_o,
  output logic                        is_mem_o,
  output logic                        is_branch_o
);
  import mips_pkg::*;

  logic is_special;
  logic is_jr;
  logic is_imm;
  logic writes_reg;

  assign is_special = (opcode_i == OP_SPECIAL);
  assign is_jr      = is_special && (function_i == FUNC_JR);

  assign is_mem_o    = (opcode_i == OP_LW) || (opcode_i == OP_SW);
  assign is_branch_o = is_jr || (opcode_i == OP_BEQ) || (opcode_i == OP_BNE);

  // Operand B comes from the immediate for I-type ALU ops and address calculation
  assign is_imm = (opcode_i == OP_ADDIU) || (opcode_i == OP_ORI) || (opcode_i == OP_LUI) ||
                  is_mem_o;

  always_comb begin
    case (opcode_i)
      OP_SPECIAL: begin
        case (function_i)
          FUNC_ADDU, FUNC_SUBU, FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_SLT: writes_reg = 1'b1;
          default: writes_reg = 1'b0;
        endcase
      end
      OP_ADDIU, OP_ORI, OP_LUI, OP_LW: writes_reg = 1'b1;
      default: writes_reg = 1'b0;
    endcase
  end

  assign src_b_sel_o          = is_imm;
  assign regfile_addr_3_sel_o = is_special ? REGFILE_ADDR_SEL_RD : REGFILE_ADDR_SEL_RT;

  // PC steps once per instruction, after the branch decision is known
  assign pc_write_en_o = (state_i == EXEC);
  assign ir_write_en_o = (state_i == FETCH);

  assign ram_read_en_o = (state_i == FETCH) || ((state_i == MEM) && (opcode_i == OP_LW));
  assign ram_write_en_o = (state_i == MEM) && (opcode_i == OP_SW);
  assign ram_addr_sel_o = (state_i == MEM);

  assign regfile_write_en_o = (state_i == WRITEBACK) && writes_reg;

endmodule

// ==== src/mips_pc.sv ====
`include "mips_cfg.svh"

module mips_pc (
  input  logic            clk,
  input  logic            arst_n_i,
  input  logic            wen_i,
  input  logic            b_cond_met_i,
  input  mips_pkg::size_t target_i,
  output mips_pkg::size_t pc_o
);
  import mips_pkg::*;

  size_t pc_q;
  // Address of the instruction after pc_q, already redirected when a branch is taken
  size_t npc_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q  <= `MIPS_RESET_VECTOR;
      npc_q <= `MIPS_RESET_VECTOR + 32'd4;
    end else if (wen_i) begin
      pc_q  <= npc_q;
      npc_q <= b_cond_met_i ? target_i : npc_q + 32'd4;
    end
  end

  assign pc_o = pc_q;

endmodule

// ==== src/mips_ir.sv ====
module mips_ir (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              wen_i,
  input  mips_pkg::size_t   instr_i,
  output mips_pkg::opcode_t opcode_o,
  output mips_pkg::func_t   funct_o,
  output mips_pkg::regaddr_t rs_o,
  output mips_pkg::regaddr_t rt_o,
  output mips_pkg::regaddr_t rd_o,
  output logic [15:0]       immediate_o
);
  import mips_pkg::*;

  size_t ir_q;

  // Cleared to an all-zero word, which decodes as a NOP
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ir_q <= '0;
    end else if (wen_i) begin
      ir_q <= instr_i;
    end
  end

  assign opcode_o    = opcode_t'(ir_q[31:26]);
  assign rs_o        = ir_q[25:21];
  assign rt_o        = ir_q[20:16];
  assign rd_o        = ir_q[15:11];
  assign funct_o     = func_t'(ir_q[5:0]);
  assign immediate_o = ir_q[15:0];

endmodule

// ==== src/mips_regfile.sv ====
`include "mips_cfg.svh"

module mips_regfile (
  input  logic               clk,
  input  logic               arst_n_i,
  input  mips_pkg::regaddr_t addr_1_i,
  input  mips_pkg::regaddr_t addr_2_i,
  input  mips_pkg::regaddr_t addr_3_i,
  input  mips_pkg::size_t    write_data_3_i,
  input  logic               write_enable_i,
  output mips_pkg::size_t    read_data_1_o,
  output mips_pkg::size_t    read_data_2_o,
  output mips_pkg::size_t    read_data_reg_v0_o
);
  import mips_pkg::*;

  localparam regaddr_t REG_V0 = 5'd2;

  size_t regs_q [`MIPS_NUM_REGS];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (write_enable_i && (addr_3_i != '0)) begin
      regs_q[addr_3_i] <= write_data_3_i;
    end
  end

  // $zero is never written but is forced anyway
  assign read_data_1_o      = (addr_1_i == '0) ? '0 : regs_q[addr_1_i];
  assign read_data_2_o      = (addr_2_i == '0) ? '0 : regs_q[addr_2_i];
  assign read_data_reg_v0_o = regs_q[REG_V0];

endmodule

// ==== src/mips_alu.sv ====
module mips_alu (
  input  logic              clk,
  input  mips_pkg::opcode_t opcode_i,
  input  mips_pkg::func_t   funct_i,
  input  logic              src_b_sel_i,
  input  mips_pkg::size_t   pc_i,
  input  mips_pkg::size_t   rs_i,
  input  mips_pkg::size_t   rt_i,
  input  logic [15:0]       immediate_i,
  output mips_pkg::size_t   result_o,
  output mips_pkg::size_t   effective_address_o,
  output logic              b_cond_met_o,
  output mips_pkg::size_t   target_o
);
  import mips_pkg::*;

  size_t imm_sext;
  size_t imm_ext;
  size_t op_b;
  size_t result_d;

  assign imm_sext = {{16{immediate_i[15]}}, immediate_i};

  always_comb begin
    case (opcode_i)
      OP_ORI:  imm_ext = {16'h0000, immediate_i};
      OP_LUI:  imm_ext = {immediate_i, 16'h0000};
      default: imm_ext = imm_sext;
    endcase
  end

  assign op_b = src_b_sel_i ? imm_ext : rt_i;

  always_comb begin
    case (opcode_i)
      OP_SPECIAL: begin
        case (funct_i)
          FUNC_ADDU: result_d = rs_i + op_b;
          FUNC_SUBU: result_d = rs_i - op_b;
          FUNC_AND:  result_d = rs_i & op_b;
          FUNC_OR:   result_d = rs_i | op_b;
          FUNC_XOR:  result_d = rs_i ^ op_b;
          FUNC_SLT:  result_d = {31'd0, $signed(rs_i) < $signed(op_b)};
          default:   result_d = '0;
        endcase
      end
      OP_ADDIU: result_d = rs_i + op_b;
      OP_ORI:   result_d = rs_i | op_b;
      OP_LUI:   result_d = op_b;
      default:  result_d = '0;
    endcase
  end

  always_comb begin
    case (opcode_i)
      OP_BEQ:     b_cond_met_o = (rs_i == rt_i);
      OP_BNE:     b_cond_met_o = (rs_i != rt_i);
      OP_SPECIAL: b_cond_met_o = (funct_i == FUNC_JR);
      default:    b_cond_met_o = 1'b0;
    endcase
  end

  // pc_i is the branch itself during EXEC, so the delay slot sits at pc_i + 4
  assign target_o = (opcode_i == OP_SPECIAL) ? rs_i :
                    pc_i + 32'd4 + {imm_sext[29:0], 2'b00};

  always_ff @(posedge clk) begin
    result_o            <= result_d;
    effective_address_o <= rs_i + imm_sext;
  end

endmodule

// ==== src/mips_cpu_bus.sv ====
`include "mips_cfg.svh"

module mips_cpu_bus (
  input  logic            clk,
  input  logic            arst_n_i,
  output logic            active_o,
  output mips_pkg::size_t register_v0_o,
  output mips_pkg::size_t address_o,
  output logic            write_o,
  output logic            read_o,
  input  logic            waitrequest_i,
  output mips_pkg::size_t writedata_o,
  output logic [3:0]      byteenable_o,
  input  mips_pkg::size_t readdata_i
);
  import mips_pkg::*;

  state_t            state;
  logic              stall;
  logic              halt;
  logic              fetch_halt;
  opcode_t           opcode;
  func_t             funct;
  regaddr_t          rs;
  regaddr_t          rt;
  regaddr_t          rd;
  regaddr_t          addr_3;
  logic [15:0]       immediate;
  logic              pc_write_en;
  logic              ir_write_en;
  logic              ir_load;
  logic              ram_read_en;
  logic              ram_write_en;
  logic              ram_addr_sel;
  logic              src_b_sel;
  logic              regfile_write_en;
  regfile_addr_sel_t addr_3_sel;
  logic              is_mem;
  logic              is_branch;
  logic              b_cond_met;
  size_t             pc;
  size_t             target;
  size_t             rs_data;
  size_t             rt_data;
  size_t             write_data_3;
  size_t             alu_result;
  size_t             effective_address;
  size_t             readdata_be;
  size_t             load_data_q;

  // Memory is big-endian, the bus is little-endian
  function automatic size_t swap_endian(size_t word);
    return {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

  assign readdata_be = swap_endian(readdata_i);

  assign halt = (pc == `MIPS_HALT_ADDR);
  // No fetch is issued from the halt address
  assign fetch_halt = halt && !ram_addr_sel;
  // The FSM sits in FETCH during reset, so the bus stays idle until release
  assign read_o     = ram_read_en && !fetch_halt && arst_n_i;
  assign write_o    = ram_write_en && arst_n_i;
  assign stall      = waitrequest_i && (read_o || write_o);
  assign ir_load    = ir_write_en && read_o && !waitrequest_i;

  mips_fsm u_fsm (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .stall_i    (stall),
    .halt_i     (halt),
    .is_mem_i   (is_mem),
    .is_branch_i(is_branch),
    .state_o    (state)
  );

  mips_control u_control (
    .state_i             (state),
    .opcode_i            (opcode),
    .function_i          (funct),
    .pc_write_en_o       (pc_write_en),
    .ir_write_en_o       (ir_write_en),
    .ram_read_en_o       (ram_read_en),
    .ram_write_en_o      (ram_write_en),
    .ram_addr_sel_o      (ram_addr_sel),
    .src_b_sel_o         (src_b_sel),
    .regfile_write_en_o  (regfile_write_en),
    .regfile_addr_3_sel_o(addr_3_sel),
    .is_mem_o            (is_mem),
    .is_branch_o         (is_branch)
  );

  mips_pc u_pc (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .wen_i       (pc_write_en),
    .b_cond_met_i(b_cond_met),
    .target_i    (target),
    .pc_o        (pc)
  );

  mips_ir u_ir (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .wen_i      (ir_load),
    .instr_i    (readdata_be),
    .opcode_o   (opcode),
    .funct_o    (funct),
    .rs_o       (rs),
    .rt_o       (rt),
    .rd_o       (rd),
    .immediate_o(immediate)
  );

  // Load data is only valid in the completing MEM cycle, hold it for WRITEBACK
  always_ff @(posedge clk) begin
    if (read_o && !waitrequest_i && ram_addr_sel) begin
      load_data_q <= readdata_be;
    end
  end

  assign addr_3       = (addr_3_sel == REGFILE_ADDR_SEL_RT) ? rt : rd;
  assign write_data_3 = (opcode == OP_LW) ? load_data_q : alu_result;

  mips_regfile u_regfile (
    .clk               (clk),
    .arst_n_i          (arst_n_i),
    .addr_1_i          (rs),
    .addr_2_i          (rt),
    .addr_3_i          (addr_3),
    .write_data_3_i    (write_data_3),
    .write_enable_i    (regfile_write_en),
    .read_data_1_o     (rs_data),
    .read_data_2_o     (rt_data),
    .read_data_reg_v0_o(register_v0_o)
  );

  mips_alu u_alu (
    .clk                (clk),
    .opcode_i           (opcode),
    .funct_i            (funct),
    .src_b_sel_i        (src_b_sel),
    .pc_i               (pc),
    .rs_i               (rs_data),
    .rt_i               (rt_data),
    .immediate_i        (immediate),
    .result_o           (alu_result),
    .effective_address_o(effective_address),
    .b_cond_met_o       (b_cond_met),
    .target_o           (target)
  );

  assign active_o     = (state != HALT) && arst_n_i;
  assign address_o    = ram_addr_sel ? effective_address : pc;
  assign writedata_o  = swap_endian(rt_data);
  assign byteenable_o = 4'b1111;

endmodule

// ==== test/mips_cpu_bus_tb.sv ====
`include "mips_cfg.svh"

module mips_cpu_bus_tb;

  localparam int          NUM_CASES    = 4;
  localparam int          HALT_TIMEOUT = 2000;
  localparam logic [31:0] RESET_VECTOR = `MIPS_RESET_VECTOR;
  localparam logic [31:0] DATA_BASE    = 32'h0000_1000;

  // Instruction encodings from the MIPS32 manual
  localparam logic [5:0] OP_ADDIU  = 6'h09;
  localparam logic [5:0] OP_ORI    = 6'h0D;
  localparam logic [5:0] OP_LUI    = 6'h0F;
  localparam logic [5:0] OP_LW     = 6'h23;
  localparam logic [5:0] OP_SW     = 6'h2B;
  localparam logic [5:0] OP_BEQ    = 6'h04;
  localparam logic [5:0] OP_BNE    = 6'h05;
  localparam logic [5:0] FN_JR     = 6'h08;
  localparam logic [5:0] FN_ADDU   = 6'h21;
  localparam logic [5:0] FN_SUBU   = 6'h23;
  localparam logic [5:0] FN_AND    = 6'h24;
  localparam logic [5:0] FN_OR     = 6'h25;
  localparam logic [5:0] FN_XOR    = 6'h26;
  localparam logic [5:0] FN_SLT    = 6'h2A;
  localparam logic [4:0] R_ZERO    = 5'd0;
  localparam logic [4:0] R_V0      = 5'd2;
  localparam logic [4:0] R_T0      = 5'd8;
  localparam logic [4:0] R_T1      = 5'd9;
  localparam logic [4:0] R_T2      = 5'd10;
  localparam logic [4:0] R_T3      = 5'd11;
  localparam logic [4:0] R_T4      = 5'd12;

  logic        clk;
  logic        arst_n      = 1'b0;
  logic        waitrequest = 1'b1;
  logic [31:0] readdata    = 32'd0;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] address;
  logic        write;
  logic        read;
  logic [31:0] writedata;
  logic [3:0]  byteenable;

  logic [31:0] prog_tbl [NUM_CASES][12];
  logic [31:0] data_tbl [NUM_CASES];
  logic [31:0] exp_v0_tbl [NUM_CASES];
  logic [31:0] exp_mem_tbl [NUM_CASES];
  logic [31:0] imem [16];
  logic [31:0] dmem [16];
  logic [15:0] lfsr       = 16'd11;
  int          xfer_count = 0;
  int          case_idx   = 0;

  mips_cpu_bus uut (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .active_o     (active),
    .register_v0_o(register_v0),
    .address_o    (address),
    .write_o      (write),
    .read_o       (read),
    .waitrequest_i(waitrequest),
    .writedata_o  (writedata),
    .byteenable_o (byteenable),
    .readdata_i   (readdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [5:0] funct);
    return {6'h00, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] swap_bytes(input logic [31:0] word);
    return {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ 32'hA5A5_5A5A;
  endfunction

  function automatic logic [31:0] mem_read(input logic [31:0] addr);
    if (addr[31:6] == RESET_VECTOR[31:6]) begin
      return imem[addr[5:2]];
    end else if (addr[31:6] == DATA_BASE[31:6]) begin
      return dmem[addr[5:2]];
    end
    return fill_word(addr);
  endfunction

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      stop_run();
    end
  endtask

  task automatic store_word(input logic [31:0] addr, input logic [31:0] word);
    if (addr[31:6] == DATA_BASE[31:6]) begin
      dmem[addr[5:2]] = word;
    end else begin
      $display("error: store to address 0x%08h outside the data region", addr);
      stop_run();
    end
  endtask

  task automatic load_memory(input int c);
    for (int i = 0; i < 16; i++) begin
      imem[i] = (i < 12) ? prog_tbl[c][i] : 32'd0;
      dmem[i] = fill_word(DATA_BASE + 32'(i * 4));
    end
    dmem[0] = data_tbl[c];
  endtask

  // Avalon slave, words kept big-endian and swapped onto the bus
  always @(posedge clk) begin
    if (!arst_n) begin
      waitrequest <= 1'b1;
      load_memory(case_idx);
    end else if (waitrequest) begin
      if (read || write) begin
        lfsr = lfsr_step(lfsr);
        if (lfsr[0]) begin
          waitrequest <= 1'b0;
          readdata    <= swap_bytes(mem_read(address));
        end
      end
    end else begin
      // DUT saw waitrequest low, this edge ends the transfer
      waitrequest <= 1'b1;
      xfer_count++;
      check_value("byteenable_o", {28'd0, byteenable}, 32'h0000_000F);
      if (write) begin
        store_word(address, swap_bytes(writedata));
      end else if (!read) begin
        $display("error: bus request dropped before waitrequest went low");
        stop_run();
      end
    end
  end

  task automatic build_table();
    for (int c = 0; c < NUM_CASES; c++) begin
      for (int i = 0; i < 12; i++) begin
        prog_tbl[c][i] = 32'd0;
      end
      data_tbl[c]    = 32'd0;
      exp_mem_tbl[c] = fill_word(DATA_BASE + 32'd4);
    end
    // ALU chain
    prog_tbl[0][0]  = i_type(OP_LUI, R_ZERO, R_T0, 16'h1234);
    prog_tbl[0][1]  = i_type(OP_ORI, R_T0, R_T0, 16'h5678);
    prog_tbl[0][2]  = i_type(OP_ADDIU, R_ZERO, R_T1, 16'hFFF0);
    prog_tbl[0][3]  = r_type(R_T0, R_T1, R_T2, FN_ADDU);
    prog_tbl[0][4]  = r_type(R_T2, R_T0, R_T2, FN_SUBU);
    prog_tbl[0][5]  = r_type(R_T2, R_T0, R_T2, FN_XOR);
    prog_tbl[0][6]  = r_type(R_T2, R_T1, R_T3, FN_AND);
    prog_tbl[0][7]  = r_type(R_T3, R_T0, R_T4, FN_SLT);
    prog_tbl[0][8]  = r_type(R_T3, R_T4, R_V0, FN_OR);
    prog_tbl[0][9]  = r_type(R_ZERO, R_ZERO, R_ZERO, FN_JR);
    // t3 is negative so the SLT gives 1
    exp_v0_tbl[0] = ((((32'h1234_5678 + 32'hFFFF_FFF0) - 32'h1234_5678) ^ 32'h1234_5678)
                    & 32'hFFFF_FFF0) | 32'd1;
    // Load, increment, store, load back
    prog_tbl[1][0]  = i_type(OP_ADDIU, R_ZERO, R_T0, DATA_BASE[15:0]);
    prog_tbl[1][1]  = i_type(OP_LW, R_T0, R_T1, 16'd0);
    prog_tbl[1][2]  = i_type(OP_ADDIU, R_T1, R_T1, 16'd1);
    prog_tbl[1][3]  = i_type(OP_SW, R_T0, R_T1, 16'd4);
    prog_tbl[1][4]  = i_type(OP_LW, R_T0, R_V0, 16'd4);
    prog_tbl[1][5]  = r_type(R_ZERO, R_ZERO, R_ZERO, FN_JR);
    data_tbl[1]    = 32'h89AB_CDEF;
    exp_v0_tbl[1]  = 32'h89AB_CDEF + 32'd1;
    exp_mem_tbl[1] = 32'h89AB_CDEF + 32'd1;
    // Taken BEQ skips words 4 and 5, BNE falls through, all delay slots run
    prog_tbl[2][0]  = i_type(OP_ADDIU, R_ZERO, R_T0, 16'd5);
    prog_tbl[2][1]  = i_type(OP_ADDIU, R_ZERO, R_T1, 16'd5);
    prog_tbl[2][2]  = i_type(OP_BEQ, R_T0, R_T1, 16'd3);
    prog_tbl[2][3]  = i_type(OP_ADDIU, R_ZERO, R_V0, 16'h0010);
    prog_tbl[2][4]  = i_type(OP_ADDIU, R_V0, R_V0, 16'h0100);
    prog_tbl[2][5]  = i_type(OP_ADDIU, R_V0, R_V0, 16'h0200);
    prog_tbl[2][6]  = i_type(OP_BNE, R_T0, R_T1, 16'd2);
    prog_tbl[2][7]  = i_type(OP_ADDIU, R_V0, R_V0, 16'h0001);
    prog_tbl[2][8]  = i_type(OP_ADDIU, R_V0, R_V0, 16'h0020);
    prog_tbl[2][9]  = r_type(R_ZERO, R_ZERO, R_ZERO, FN_JR);
    prog_tbl[2][10] = i_type(OP_ADDIU, R_V0, R_V0, 16'h0400);
    exp_v0_tbl[2] = 32'h0010 + 32'h0001 + 32'h0020 + 32'h0400;
    // Signed compare that is false, then a wrapping subtract
    prog_tbl[3][0]  = i_type(OP_ADDIU, R_ZERO, R_T0, 16'hFFFE);
    prog_tbl[3][1]  = i_type(OP_ADDIU, R_ZERO, R_T1, 16'd3);
    prog_tbl[3][2]  = r_type(R_T1, R_T0, R_T2, FN_SLT);
    prog_tbl[3][3]  = r_type(R_T2, R_T1, R_V0, FN_SUBU);
    prog_tbl[3][4]  = r_type(R_ZERO, R_ZERO, R_ZERO, FN_JR);
    exp_v0_tbl[3] = 32'd0 - 32'd3;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (5) begin
      @(negedge clk);
      check_value("active_o", {31'd0, active}, 32'd0);
      check_value("read_o", {31'd0, read}, 32'd0);
      check_value("write_o", {31'd0, write}, 32'd0);
    end
    @(posedge clk);
    arst_n <= 1'b1;
  endtask

  task automatic run_case(input int c);
    int          cycles;
    int          xfers_hold;
    logic [31:0] v0_hold;
    case_idx = c;
    apply_reset();
    // The fetch of the reset vector starts in the first cycle after release
    @(negedge clk);
    check_value("read_o", {31'd0, read}, 32'd1);
    check_value("address_o", address, RESET_VECTOR);
    check_value("active_o", {31'd0, active}, 32'd1);
    cycles = 0;
    while (active) begin
      if (cycles == HALT_TIMEOUT) begin
        $display("error: core did not halt within %0d cycles in case %0d", HALT_TIMEOUT, c);
        stop_run();
      end else begin
        cycles++;
        @(negedge clk);
      end
    end
    // Halted core stays quiet on the bus
    v0_hold    = register_v0;
    xfers_hold = xfer_count;
    repeat (5) begin
      @(negedge clk);
      check_value("active_o", {31'd0, active}, 32'd0);
      check_value("read_o", {31'd0, read}, 32'd0);
      check_value("write_o", {31'd0, write}, 32'd0);
      check_value("register_v0_o", register_v0, v0_hold);
    end
    check_value("bus transfer count", 32'(xfer_count), 32'(xfers_hold));
    check_value("register_v0_o", register_v0, exp_v0_tbl[c]);
    check_value("data word 1", dmem[1], exp_mem_tbl[c]);
    $display("case %0d done, v0 = 0x%08h after %0d transfers", c, register_v0, xfer_count);
  endtask

  initial begin
    build_table();
    for (int c = 0; c < NUM_CASES; c++) begin
      run_case(c);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+src
src/mips_pkg.sv
src/mips_fsm.sv
src/mips_control.sv
src/mips_pc.sv
src/mips_ir.sv
src/mips_regfile.sv
src/mips_alu.sv
src/mips_cpu_bus.sv
test/mips_cpu_bus_tb.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := mips_cpu_bus_tb
FILELIST := sources.f

OBJ_DIR  := obj_dir
SIM      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS  := $(wildcard src/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
